/* verilog/conv_pkg.sv */
// Shared definitions for the two-layer image feature engine
// Fixed-point types, kernel constants, memory selects and controller states

package conv_pkg;

  // Q4.16 pixel format and memory geometry
  localparam int data_w = 20;
  localparam int frac_w = 16;
  localparam int addr_w = 12;
  localparam int acc_w  = 44;

  typedef logic signed [data_w-1:0] data_t;
  typedef logic        [addr_w-1:0] addr_t;
  typedef logic signed [acc_w-1:0]  acc_t;

  typedef struct packed {
    logic [5:0] row;
    logic [5:0] col;
  } pos_t;

  typedef struct packed {
    logic       valid;
    logic [3:0] tap;
  } fetch_step_t;

  // Nine taps, index 0 is the top-left neighbour
  typedef data_t [8:0] window_t;

  typedef struct packed {
    data_t ch0;
    data_t ch1;
  } conv_result_t;

  typedef enum logic [2:0] {
    csel_none   = 3'd0,
    csel_l0_ch0 = 3'd1,
    csel_l0_ch1 = 3'd2,
    csel_l1_ch0 = 3'd3,
    csel_l1_ch1 = 3'd4
  } csel_e;

  typedef enum logic [2:0] {
    st_idle,
    st_fetch,
    st_compute,
    st_write_l0,
    st_pool_read,
    st_write_l1,
    st_done
  } ctrl_state_e;

  // Kernel weights and biases as true signed Q4.16 values
  localparam data_t kernel_0 [0:8] = '{
    20'h0A89E, 20'h092D5, 20'h06D43,
    20'h01004, 20'hF8F71, 20'hF6E54,
    20'hFA6D7, 20'hFC834, 20'hFAC19
  };
  localparam data_t kernel_1 [0:8] = '{
    20'hFDB55, 20'h02992, 20'hFC994,
    20'h050FD, 20'h02F20, 20'h0202D,
    20'h03BD7, 20'hFD369, 20'h05E68
  };
  localparam data_t bias_0 = 20'h01310;
  localparam data_t bias_1 = 20'hF7295;

endpackage

/* verilog/conv_ctrl.sv */
// Sequencing controller for the feature engine
// Walks every pixel through fetch, compute and layer-0 write, then every
// 2x2 block through pooling reads and the layer-1 write

`timescale 1ns/10ps

module conv_ctrl #(
  parameter int img_side_log2 = 6
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ready,
  input  conv_pkg::conv_result_t conv_res,
  input  conv_pkg::data_t       pool_max,
  output logic                  busy,
  output conv_pkg::fetch_step_t fetch_step,
  output conv_pkg::pos_t        pos,
  output logic                  compute,
  output logic                  pool_capture,
  output logic [1:0]            pool_slot,
  output conv_pkg::csel_e       csel,
  output logic                  cwr,
  output conv_pkg::addr_t       caddr_wr,
  output conv_pkg::data_t       cdata_wr,
  output logic                  crd,
  output conv_pkg::addr_t       caddr_rd
);
  import conv_pkg::*;

  localparam logic [5:0] last_idx = 6'((1 << img_side_log2) - 1);
  localparam logic [5:0] last_blk = 6'((1 << img_side_log2) - 2);

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  logic [3:0]  step;
  logic        step_last;
  pos_t        blk;
  logic        pool_ch;
  logic        pix_last;
  logic        blk_last;
  addr_t       pix_addr;
  addr_t       blk_base;
  addr_t       rd_addr;
  addr_t       l1_addr;

  // ====================================================================
  // State machine
  // ====================================================================

  always_comb begin
    case (state)
      st_fetch:     step_last = (step == 4'd9);
      st_write_l0:  step_last = (step == 4'd1);
      st_pool_read: step_last = (step == 4'd4);
      default:      step_last = 1'b1;
    endcase
  end

  assign pix_last = (pos.row == last_idx) && (pos.col == last_idx);
  assign blk_last = (blk.row == last_blk) && (blk.col == last_blk);

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:      if (ready) state_nxt = st_fetch;
      st_fetch:     if (step_last) state_nxt = st_compute;
      st_compute:   state_nxt = st_write_l0;
      st_write_l0: begin
        if (step_last) state_nxt = pix_last ? st_pool_read : st_fetch;
      end
      st_pool_read: if (step_last) state_nxt = st_write_l1;
      st_write_l1:  state_nxt = (pool_ch && blk_last) ? st_done : st_pool_read;
      st_done:      state_nxt = st_idle;
      default:      state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_idle;
      step  <= '0;
      busy  <= 1'b0;
    end else begin
      state <= state_nxt;
      step  <= (state_nxt != state || step_last) ? 4'd0 : step + 4'd1;
      if (state == st_idle && ready) begin
        busy <= 1'b1;
      end else if (state == st_done) begin
        busy <= 1'b0;
      end
    end
  end

  // Pixel walk is row-major, block walk steps by two in both directions
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pos     <= '0;
      blk     <= '0;
      pool_ch <= 1'b0;
    end else begin
      if (state == st_write_l0 && step_last) begin
        if (pos.col == last_idx) begin
          pos.col <= '0;
          pos.row <= (pos.row == last_idx) ? 6'd0 : pos.row + 6'd1;
        end else begin
          pos.col <= pos.col + 6'd1;
        end
      end
      if (state == st_write_l1) begin
        pool_ch <= ~pool_ch;
        if (pool_ch) begin
          if (blk.col == last_blk) begin
            blk.col <= '0;
            blk.row <= (blk.row == last_blk) ? 6'd0 : blk.row + 6'd2;
          end else begin
            blk.col <= blk.col + 6'd2;
          end
        end
      end
    end
  end

  assign fetch_step.valid = (state == st_fetch) && (step < 4'd9);
  assign fetch_step.tap   = step;
  assign compute          = (state == st_compute);

  // ====================================================================
  // Layer memory ports
  // ====================================================================

  assign pix_addr = (addr_t'(pos.row) << img_side_log2) | addr_t'(pos.col);
  assign blk_base = (addr_t'(blk.row) << img_side_log2) | addr_t'(blk.col);
  // Slot order is top-left, top-right, bottom-left, bottom-right
  assign rd_addr  = blk_base + (addr_t'(step[1]) << img_side_log2) + addr_t'(step[0]);
  assign l1_addr  = (addr_t'(blk.row[5:1]) << (img_side_log2 - 1)) | addr_t'(blk.col[5:1]);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cwr          <= 1'b0;
      crd          <= 1'b0;
      csel         <= csel_none;
      caddr_wr     <= '0;
      cdata_wr     <= '0;
      caddr_rd     <= '0;
      pool_capture <= 1'b0;
      pool_slot    <= '0;
    end else begin
      cwr          <= 1'b0;
      crd          <= 1'b0;
      csel         <= csel_none;
      pool_capture <= 1'b0;
      case (state)
        st_write_l0: begin
          cwr      <= 1'b1;
          caddr_wr <= pix_addr;
          if (step == 4'd0) begin
            csel     <= csel_l0_ch0;
            cdata_wr <= conv_res.ch0;
          end else begin
            csel     <= csel_l0_ch1;
            cdata_wr <= conv_res.ch1;
          end
        end
        st_pool_read: begin
          // Read data returns in the next cycle, captured there
          if (step < 4'd4) begin
            crd          <= 1'b1;
            csel         <= pool_ch ? csel_l0_ch1 : csel_l0_ch0;
            caddr_rd     <= rd_addr;
            pool_capture <= 1'b1;
            pool_slot    <= step[1:0];
          end
        end
        st_write_l1: begin
          cwr      <= 1'b1;
          csel     <= pool_ch ? csel_l1_ch1 : csel_l1_ch0;
          caddr_wr <= l1_addr;
          cdata_wr <= pool_max;
        end
        default: begin
        end
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(cwr && crd))
    else $error("cwr and crd high together");

  assert property (@(posedge clk) disable iff (reset) (cwr || crd) |-> csel != csel_none)
    else $error("memory strobe with no memory selected");

endmodule

/* verilog/window_fetch.sv */
// 3x3 window fetch with zero padding
// Generates the image address of each tap and captures the returned pixel,
// or zero for taps outside the image

`timescale 1ns/10ps

module window_fetch #(
  parameter int img_side_log2 = 6
) (
  input  logic                  clk,
  input  logic                  reset,
  input  conv_pkg::fetch_step_t fetch_step,
  input  conv_pkg::pos_t        pos,
  input  conv_pkg::data_t       idata,
  output conv_pkg::addr_t       iaddr,
  output conv_pkg::window_t     window
);
  import conv_pkg::*;

  localparam logic signed [7:0] side = 8'(1 << img_side_log2);

  logic signed [7:0] dr;
  logic signed [7:0] dc;
  logic signed [7:0] nr;
  logic signed [7:0] nc;
  logic              outside;
  addr_t             nb_addr;
  fetch_step_t       tap_q;
  logic              pad_q;

  // Tap offsets in row-major order around the centre
  always_comb begin
    case (fetch_step.tap)
      4'd0, 4'd1, 4'd2: dr = -8'sd1;
      4'd3, 4'd4, 4'd5: dr = 8'sd0;
      default:          dr = 8'sd1;
    endcase
    case (fetch_step.tap)
      4'd0, 4'd3, 4'd6: dc = -8'sd1;
      4'd1, 4'd4, 4'd7: dc = 8'sd0;
      default:          dc = 8'sd1;
    endcase
  end

  assign nr      = $signed({2'b00, pos.row}) + dr;
  assign nc      = $signed({2'b00, pos.col}) + dc;
  assign outside = (nr < 0) || (nr >= side) || (nc < 0) || (nc >= side);
  assign nb_addr = (addr_t'(nr[5:0]) << img_side_log2) | addr_t'(nc[5:0]);

  // Address goes out this edge, the pixel comes back one edge later
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      iaddr <= '0;
      tap_q <= '0;
      pad_q <= 1'b0;
    end else begin
      tap_q <= fetch_step;
      if (fetch_step.valid) begin
        iaddr <= nb_addr;
        pad_q <= outside;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tap_q.valid) begin
      window[tap_q.tap] <= pad_q ? data_t'(0) : idata;
    end
  end

endmodule

/* verilog/conv_mac.sv */
// Two-channel 3x3 multiply-accumulate
// Applies both kernels to the held window, adds bias, rounds half up and
// clamps through ReLU, then registers the pair on compute

`timescale 1ns/10ps

module conv_mac (
  input  logic                   clk,
  input  logic                   reset,
  input  conv_pkg::window_t      window,
  input  logic                   compute,
  output conv_pkg::conv_result_t result
);
  import conv_pkg::*;

  data_t ch0_out;
  data_t ch1_out;

  // One output channel from the window, a kernel and its bias
  function automatic data_t channel_out(
    input window_t w,
    input data_t   k [0:8],
    input data_t   b
  );
    acc_t  sum;
    acc_t  rnd;
    data_t q;
    // Bias moves up to the Q8.32 product fraction
    sum = acc_t'(b) <<< frac_w;
    for (int i = 0; i < 9; i++) begin
      sum = sum + acc_t'(w[i]) * acc_t'(k[i]);
    end
    // Half up at the first dropped fraction bit
    rnd = sum + (acc_t'(1) <<< (frac_w - 1));
    q   = data_t'(rnd[frac_w+data_w-1:frac_w]);
    return (q > 0) ? q : data_t'(0);
  endfunction

  always_comb begin
    ch0_out = channel_out(window, kernel_0, bias_0);
    ch1_out = channel_out(window, kernel_1, bias_1);
  end

  always_ff @(posedge clk) begin
    if (compute) begin
      result.ch0 <= ch0_out;
      result.ch1 <= ch1_out;
    end
  end

  // Each pixel gets exactly one compute cycle after its fetch
  assert property (@(posedge clk) disable iff (reset) compute |=> !compute)
    else $error("compute held for two cycles");

endmodule

/* verilog/maxpool_unit.sv */
// 2x2 max pooling
// Holds four layer-0 values and gives their maximum

`timescale 1ns/10ps

module maxpool_unit (
  input  logic            clk,
  input  logic            reset,
  input  logic            pool_capture,
  input  logic [1:0]      pool_slot,
  input  conv_pkg::data_t cdata_rd,
  output conv_pkg::data_t pool_max
);
  import conv_pkg::*;

  data_t slot_q [0:3];
  data_t max_top;
  data_t max_bot;

  // Plain magnitude compare, valid for ReLU outputs only
  function automatic data_t max_u(input data_t a, input data_t b);
    return ($unsigned(a) > $unsigned(b)) ? a : b;
  endfunction

  always_ff @(posedge clk) begin
    if (pool_capture) begin
      slot_q[pool_slot] <= cdata_rd;
    end
  end

  always_comb begin
    max_top  = max_u(slot_q[0], slot_q[1]);
    max_bot  = max_u(slot_q[2], slot_q[3]);
    pool_max = max_u(max_top, max_bot);
  end

  // Layer-0 data comes out of ReLU, so the sign bit is always clear
  assert property (@(posedge clk) disable iff (reset) pool_capture |-> !cdata_rd[data_w-1])
    else $error("negative layer-0 value captured for pooling");

endmodule

/* verilog/conv_top.sv */
// Image feature engine top level
// Connects the controller, window fetch, MAC and pooling units to the
// image memory and layer memory ports

`timescale 1ns/10ps

module conv_top #(
  parameter int img_side_log2 = 6
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            ready,
  input  conv_pkg::data_t idata,
  input  conv_pkg::data_t cdata_rd,
  output logic            busy,
  output conv_pkg::addr_t iaddr,
  output logic [2:0]      csel,
  output logic            cwr,
  output conv_pkg::addr_t caddr_wr,
  output conv_pkg::data_t cdata_wr,
  output logic            crd,
  output conv_pkg::addr_t caddr_rd
);
  import conv_pkg::*;

  fetch_step_t  fetch_step;
  pos_t         pos;
  window_t      window;
  logic         compute;
  conv_result_t conv_res;
  logic         pool_capture;
  logic [1:0]   pool_slot;
  data_t        pool_max;

  conv_ctrl #(
    .img_side_log2(img_side_log2)
  ) u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .ready       (ready),
    .conv_res    (conv_res),
    .pool_max    (pool_max),
    .busy        (busy),
    .fetch_step  (fetch_step),
    .pos         (pos),
    .compute     (compute),
    .pool_capture(pool_capture),
    .pool_slot   (pool_slot),
    .csel        (csel),
    .cwr         (cwr),
    .caddr_wr    (caddr_wr),
    .cdata_wr    (cdata_wr),
    .crd         (crd),
    .caddr_rd    (caddr_rd)
  );

  window_fetch #(
    .img_side_log2(img_side_log2)
  ) u_fetch (
    .clk       (clk),
    .reset     (reset),
    .fetch_step(fetch_step),
    .pos       (pos),
    .idata     (idata),
    .iaddr     (iaddr),
    .window    (window)
  );

  conv_mac u_mac (
    .clk    (clk),
    .reset  (reset),
    .window (window),
    .compute(compute),
    .result (conv_res)
  );

  maxpool_unit u_pool (
    .clk         (clk),
    .reset       (reset),
    .pool_capture(pool_capture),
    .pool_slot   (pool_slot),
    .cdata_rd    (cdata_rd),
    .pool_max    (pool_max)
  );

endmodule

/* verif/tb_model.svh */
// Reference model for the feature engine testbench
// LCG image fill and expected layer-0 and layer-1 values

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

// Zero outside the image
function automatic data_t pixel_at(input int r, input int c);
  data_t p;
  p = '0;
  if (r >= 0 && r < side && c >= 0 && c < side) begin
    p = img_mem[12'(r * side + c)];
  end
  return p;
endfunction

function automatic data_t l0_value(input int ch, input int r, input int c);
  longint sum;
  longint w;
  data_t  q;
  // Bias lifted to the 32-bit product fraction
  sum = ((ch == 0) ? longint'(bias_0) : longint'(bias_1)) * 65536;
  for (int i = 0; i < 9; i++) begin
    w = (ch == 0) ? longint'(kernel_0[4'(i)]) : longint'(kernel_1[4'(i)]);
    sum = sum + longint'(pixel_at(r + i / 3 - 1, c + i % 3 - 1)) * w;
  end
  // Round half up, then back to Q4.16
  q = data_t'((sum + 64'sd32768) >>> 16);
  if (q[data_w-1] || q == '0) begin
    q = '0;
  end
  return q;
endfunction

function automatic data_t block_max(input int ch, input int b);
  int    r0;
  int    c0;
  addr_t idx;
  data_t v;
  data_t m;
  r0 = (b / (side / 2)) * 2;
  c0 = (b % (side / 2)) * 2;
  m  = '0;
  for (int i = 0; i < 4; i++) begin
    idx = 12'((r0 + i / 2) * side + c0 + i % 2);
    v   = (ch == 0) ? exp_l0_ch0[idx] : exp_l0_ch1[idx];
    if (v > m) begin
      m = v;
    end
  end
  return m;
endfunction

task automatic fill_image();
  logic [31:0] s;
  s = 32'd21596;
  for (int a = 0; a < px_count; a++) begin
    s = lcg_next(s);
    // Upper LCG bits as a pixel in [0, 1.0)
    img_mem[12'(a)] = data_t'({4'b0000, s[31:16]});
  end
endtask

task automatic build_expected();
  for (int a = 0; a < px_count; a++) begin
    exp_l0_ch0[12'(a)] = l0_value(0, a / side, a % side);
    exp_l0_ch1[12'(a)] = l0_value(1, a / side, a % side);
  end
  for (int b = 0; b < blk_count; b++) begin
    exp_l1_ch0[10'(b)] = block_max(0, b);
    exp_l1_ch1[10'(b)] = block_max(1, b);
  end
endtask

`endif

/* verif/tb_conv.sv */
// Testbench for the image feature engine
// Models the image and layer memories and checks both layers with assertions

`timescale 1ns/10ps

module tb_conv;
  import conv_pkg::*;

  localparam int side_log2 = 6;
  localparam int side      = 1 << side_log2;
  localparam int px_count  = side * side;
  localparam int blk_count = px_count / 4;
  // Twice about 13 cycles per pixel and 12 per block plus slack
  localparam int timeout_cycles = 2 * (13 * px_count + 12 * blk_count) + 8000;

  logic       clk = 1'b0;
  logic       reset;
  logic       ready;
  data_t      idata;
  data_t      cdata_rd;
  logic       busy;
  addr_t      iaddr;
  logic [2:0] csel;
  logic       cwr;
  addr_t      caddr_wr;
  data_t      cdata_wr;
  logic       crd;
  addr_t      caddr_rd;

  data_t img_mem    [0:px_count-1];
  data_t l0_mem0    [0:px_count-1];
  data_t l0_mem1    [0:px_count-1];
  data_t l1_mem0    [0:blk_count-1];
  data_t l1_mem1    [0:blk_count-1];
  data_t exp_l0_ch0 [0:px_count-1];
  data_t exp_l0_ch1 [0:px_count-1];
  data_t exp_l1_ch0 [0:blk_count-1];
  data_t exp_l1_ch1 [0:blk_count-1];
  logic  l0_seen0   [0:px_count-1] = '{default: 1'b0};
  logic  l0_seen1   [0:px_count-1] = '{default: 1'b0};
  logic  l1_seen0   [0:blk_count-1] = '{default: 1'b0};
  logic  l1_seen1   [0:blk_count-1] = '{default: 1'b0};
  int    l0_count0 = 0;
  int    l0_count1 = 0;
  int    l1_count0 = 0;
  int    l1_count1 = 0;
  logic  read_seen = 1'b0;

  `include "tb_model.svh"

  always #5 clk = ~clk;

  conv_top #(
    .img_side_log2(side_log2)
  ) uut (
    .clk     (clk),
    .reset   (reset),
    .ready   (ready),
    .idata   (idata),
    .cdata_rd(cdata_rd),
    .busy    (busy),
    .iaddr   (iaddr),
    .csel    (csel),
    .cwr     (cwr),
    .caddr_wr(caddr_wr),
    .cdata_wr(cdata_wr),
    .crd     (crd),
    .caddr_rd(caddr_rd)
  );

  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("error: %s", msg);
    abort_run();
  endtask

  task automatic report_mismatch(input string name, input data_t got, input data_t exp);
    $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    abort_run();
  endtask

  // ====================================================================
  // Memory models
  // ====================================================================

  assign idata = img_mem[iaddr];

  always_comb begin
    case (csel)
      csel_l0_ch0: cdata_rd = l0_mem0[caddr_rd];
      csel_l0_ch1: cdata_rd = l0_mem1[caddr_rd];
      csel_l1_ch0: cdata_rd = l1_mem0[caddr_rd[9:0]];
      csel_l1_ch1: cdata_rd = l1_mem1[caddr_rd[9:0]];
      default:     cdata_rd = '0;
    endcase
  end

  // Writes plus bookkeeping for the coverage checks
  always @(posedge clk) begin
    if (cwr) begin
      case (csel)
        csel_l0_ch0: begin
          l0_mem0[caddr_wr]  <= cdata_wr;
          l0_seen0[caddr_wr] <= 1'b1;
          l0_count0          <= l0_count0 + 1;
        end
        csel_l0_ch1: begin
          l0_mem1[caddr_wr]  <= cdata_wr;
          l0_seen1[caddr_wr] <= 1'b1;
          l0_count1          <= l0_count1 + 1;
        end
        csel_l1_ch0: begin
          l1_mem0[caddr_wr[9:0]]  <= cdata_wr;
          l1_seen0[caddr_wr[9:0]] <= 1'b1;
          l1_count0               <= l1_count0 + 1;
        end
        csel_l1_ch1: begin
          l1_mem1[caddr_wr[9:0]]  <= cdata_wr;
          l1_seen1[caddr_wr[9:0]] <= 1'b1;
          l1_count1               <= l1_count1 + 1;
        end
        default: begin
        end
      endcase
    end
    if (crd) begin
      read_seen <= 1'b1;
    end
  end

  // ====================================================================
  // Checks
  // ====================================================================

  assert property (@(posedge clk) reset |-> !busy && !cwr && !crd && csel == 3'd0)
    else report_error("outputs not idle during reset");
  assert property (@(posedge clk) $fell(reset) |-> !busy && !cwr && !crd && csel == 3'd0)
    else report_error("outputs not idle in the first cycle after reset");
  assert property (@(posedge clk) disable iff (reset) ready && !busy |=> busy)
    else report_error("busy did not rise after ready");
  assert property (@(posedge clk) disable iff (reset) !ready && !busy |=> !busy)
    else report_error("busy rose without a ready pulse");

  // Layer 0
  assert property (@(posedge clk) disable iff (reset)
    cwr && csel == csel_l0_ch0 |-> cdata_wr == exp_l0_ch0[caddr_wr])
    else report_mismatch("cdata_wr", $sampled(cdata_wr), exp_l0_ch0[$sampled(caddr_wr)]);
  assert property (@(posedge clk) disable iff (reset)
    cwr && csel == csel_l0_ch1 |-> cdata_wr == exp_l0_ch1[caddr_wr])
    else report_mismatch("cdata_wr", $sampled(cdata_wr), exp_l0_ch1[$sampled(caddr_wr)]);
  assert property (@(posedge clk) disable iff (reset)
    !(cwr && ((csel == csel_l0_ch0 && l0_seen0[caddr_wr]) ||
              (csel == csel_l0_ch1 && l0_seen1[caddr_wr]))))
    else report_error("layer-0 address written twice");
  assert property (@(posedge clk) disable iff (reset)
    cwr && (csel == csel_l0_ch0 || csel == csel_l0_ch1) |-> !read_seen)
    else report_error("layer-0 write after pooling reads began");
  assert property (@(posedge clk) disable iff (reset)
    crd && !read_seen |-> l0_count0 == px_count && l0_count1 == px_count)
    else report_error("pooling started before layer 0 was complete");

  // Layer 1
  assert property (@(posedge clk) disable iff (reset)
    crd |-> csel == csel_l0_ch0 || csel == csel_l0_ch1)
    else report_error("read from a memory other than layer 0");
  assert property (@(posedge clk) disable iff (reset)
    cwr && (csel == csel_l1_ch0 || csel == csel_l1_ch1) |-> caddr_wr < 12'(blk_count))
    else report_error("layer-1 write address out of range");
  assert property (@(posedge clk) disable iff (reset)
    cwr && csel == csel_l1_ch0 |-> cdata_wr == exp_l1_ch0[caddr_wr[9:0]])
    else report_mismatch("cdata_wr", $sampled(cdata_wr), exp_l1_ch0[$sampled(caddr_wr[9:0])]);
  assert property (@(posedge clk) disable iff (reset)
    cwr && csel == csel_l1_ch1 |-> cdata_wr == exp_l1_ch1[caddr_wr[9:0]])
    else report_mismatch("cdata_wr", $sampled(cdata_wr), exp_l1_ch1[$sampled(caddr_wr[9:0])]);
  assert property (@(posedge clk) disable iff (reset)
    !(cwr && ((csel == csel_l1_ch0 && l1_seen0[caddr_wr[9:0]]) ||
              (csel == csel_l1_ch1 && l1_seen1[caddr_wr[9:0]]))))
    else report_error("layer-1 address written twice");
  assert property (@(posedge clk) disable iff (reset) !(cwr && crd))
    else report_error("write and read strobes high together");
  assert property (@(posedge clk) disable iff (reset)
    $fell(busy) |-> l1_count0 == blk_count && l1_count1 == blk_count)
    else report_error("busy fell before layer 1 was complete");

  // ====================================================================
  // Stimulus
  // ====================================================================

  initial begin
    reset = 1'b1;
    ready = 1'b0;
    fill_image();
    build_expected();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);
    ready <= 1'b1;
    @(posedge clk);
    ready <= 1'b0;
    wait (busy);
    @(negedge busy);
    // Leave time for busy to be seen low and stay low
    repeat (10) @(posedge clk);
    $display("sim passed");
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    report_error("run timed out before busy fell");
  end

endmodule

/* flist.f */
+incdir+verif
verilog/conv_pkg.sv
verilog/conv_ctrl.sv
verilog/window_fetch.sv
verilog/conv_mac.sv
verilog/maxpool_unit.sv
verilog/conv_top.sv
verif/tb_conv.sv

/* Makefile */
# Verilator build and run for the image feature engine

TOP := tb_conv
OBJ := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): flist.f $(wildcard verilog/*.sv verif/*.sv verif/*.svh)
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir $(OBJ)

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module conv_top
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) sim.log
